//--- cplx_mixer.sv
module cplx_mixer (
  input  logic                 clk,
  input  logic                 i_rst,
  input  tag_rx_pkg::trig_t    i_trig,
  input  tag_rx_pkg::iq_t      i_sample,
  output tag_rx_pkg::wide_iq_t o_mix
);
  import tag_rx_pkg::*;

  logic signed [WIDE_W-1:0] i_cos, q_sin, q_cos, i_sin;
  logic signed [WIDE_W-1:0] mix_i, mix_q;
  wide_iq_t                 mix_q_reg;

  // products are sign extended to the wide width before the sums.
  assign i_cos = i_sample.i * i_trig.cos;
  assign q_sin = i_sample.q * i_trig.sin;
  assign q_cos = i_sample.q * i_trig.cos;
  assign i_sin = i_sample.i * i_trig.sin;

  // multiply by cos - j*sin, the conjugate of the local tone.
  assign mix_i = i_cos + q_sin;
  assign mix_q = q_cos - i_sin;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      mix_q_reg.valid <= 1'b0;
    end else begin
      mix_q_reg.valid <= i_sample.valid & i_trig.valid;
    end
    mix_q_reg.last <= i_trig.last;
    mix_q_reg.i    <= mix_i;
    mix_q_reg.q    <= mix_q;
  end

  assign o_mix = mix_q_reg;

endmodule

//--- dds_sincos.sv
module dds_sincos (
  input  logic                           clk,
  input  logic                           i_rst,
  input  logic [tag_rx_pkg::PHASE_W-1:0] i_phase,
  input  tag_rx_pkg::iq_t                i_sample,
  output tag_rx_pkg::trig_t              o_trig,
  output tag_rx_pkg::iq_t                o_sample
);
  import tag_rx_pkg::*;

  localparam int  LUT_N = 2 ** LUT_BITS;
  localparam real PI    = 3.14159265358979;
  localparam real FULL  = real'((2 ** (TRIG_W - 1)) - 1);

  // round to nearest, halves away from zero.
  function automatic logic signed [TRIG_W-1:0] to_fixed(input real x);
    real y;
    y = x * FULL;
    if (y >= 0.0) begin
      return TRIG_W'($rtoi(y + 0.5));
    end
    return TRIG_W'(-$rtoi(0.5 - y));
  endfunction

  logic signed [TRIG_W-1:0] sin_lut [LUT_N];
  logic signed [TRIG_W-1:0] cos_lut [LUT_N];
  logic [LUT_BITS-1:0]      addr;
  trig_t                    trig_q;
  iq_t                      sample_q;

  // one full cycle, so no quadrant folding is needed.
  for (genvar k = 0; k < LUT_N; k++) begin : g_lut
    localparam real ANG = 2.0 * PI * k / LUT_N;
    localparam logic signed [TRIG_W-1:0] SIN_V = to_fixed($sin(ANG));
    localparam logic signed [TRIG_W-1:0] COS_V = to_fixed($cos(ANG));
    assign sin_lut[k] = SIN_V;
    assign cos_lut[k] = COS_V;
  end

  assign addr = i_phase[PHASE_W-1 -: LUT_BITS];

  always_ff @(posedge clk) begin
    if (i_rst) begin
      trig_q.valid   <= 1'b0;
      sample_q.valid <= 1'b0;
    end else begin
      trig_q.valid   <= i_sample.valid;
      sample_q.valid <= i_sample.valid;
    end
    trig_q.last   <= i_sample.last;
    trig_q.sin    <= sin_lut[addr];
    trig_q.cos    <= cos_lut[addr];
    sample_q.last <= i_sample.last;
    sample_q.i    <= i_sample.i;
    sample_q.q    <= i_sample.q;
  end

  assign o_trig   = trig_q;
  assign o_sample = sample_q;

endmodule

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb -f tb.f -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

//--- scale_round_clip.sv
module scale_round_clip #(
  parameter int SCALE_NUM   = 1,
  parameter int SCALE_SHIFT = 15
) (
  input  logic                 clk,
  input  logic                 i_rst,
  input  tag_rx_pkg::wide_iq_t i_mix,
  output tag_rx_pkg::iq_t      o_out
);
  import tag_rx_pkg::*;

  localparam int NUM_W = $clog2(SCALE_NUM + 1) + 1;
  localparam int SUM_W = WIDE_W + NUM_W + 1; // one spare bit for the rounding add.

  localparam logic signed [NUM_W-1:0] GAIN     = NUM_W'(SCALE_NUM);
  localparam logic signed [SUM_W-1:0] HALF     = SUM_W'(1) << (SCALE_SHIFT - 1);
  localparam logic signed [SUM_W-1:0] OUT_MAX  = SUM_W'((2 ** (DATA_W - 1)) - 1);
  localparam logic signed [SUM_W-1:0] OUT_MIN  = -SUM_W'(2 ** (DATA_W - 1));

  // gain, round half up, then saturate one component.
  function automatic logic signed [DATA_W-1:0] scale_one(input logic signed [WIDE_W-1:0] x);
    logic signed [SUM_W-1:0] prod;
    logic signed [SUM_W-1:0] rnd;
    prod = x * GAIN;
    rnd  = (prod + HALF) >>> SCALE_SHIFT;
    if (rnd > OUT_MAX) begin
      return DATA_W'(OUT_MAX);
    end
    if (rnd < OUT_MIN) begin
      return DATA_W'(OUT_MIN);
    end
    return DATA_W'(rnd);
  endfunction

  iq_t out_q;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      out_q.valid <= 1'b0;
    end else begin
      out_q.valid <= i_mix.valid;
    end
    out_q.last <= i_mix.last;
    out_q.i    <= scale_one(i_mix.i);
    out_q.q    <= scale_one(i_mix.q);
  end

  assign o_out = out_q;

endmodule

//--- tag_rx.sv
module tag_rx #(
  parameter int                            NSIG         = 8,
  parameter int                            NSYMB        = 4,
  parameter logic [tag_rx_pkg::PHASE_W-1:0] DPH_INC      = 24'h080000,
  parameter logic [tag_rx_pkg::PHASE_W-1:0] START_PH     = 24'h000000,
  parameter logic [tag_rx_pkg::PHASE_W-1:0] START_PH_INC = 24'h100000,
  parameter int                            RX_SYNC_BITS = 2,
  parameter int                            SCALE_NUM    = 1,
  parameter int                            SCALE_SHIFT  = 15
) (
  input  logic                           clk,
  input  logic                           i_rst,
  input  logic                           i_srst,
  input  tag_rx_pkg::iq_t                i_in,
  output tag_rx_pkg::iq_t                o_out,
  output logic                           o_sync_ready,
  output logic [tag_rx_pkg::PHASE_W-1:0] o_phase,
  output logic [$clog2(NSYMB+1)-1:0]     o_symb_idx
);
  import tag_rx_pkg::*;

  iq_t                seq_sample;
  logic [PHASE_W-1:0] seq_phase;
  trig_t              dds_trig;
  iq_t                dds_sample;
  wide_iq_t           mix;

  tag_rx_seq #(
    .NSIG         (NSIG),
    .NSYMB        (NSYMB),
    .DPH_INC      (DPH_INC),
    .START_PH     (START_PH),
    .START_PH_INC (START_PH_INC),
    .RX_SYNC_BITS (RX_SYNC_BITS)
  ) u_seq (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_srst       (i_srst),
    .i_in         (i_in),
    .o_sample     (seq_sample),
    .o_phase      (seq_phase),
    .o_symb_idx   (o_symb_idx),
    .o_sync_ready (o_sync_ready)
  );

  dds_sincos u_dds (
    .clk      (clk),
    .i_rst    (i_rst),
    .i_phase  (seq_phase),
    .i_sample (seq_sample),
    .o_trig   (dds_trig),
    .o_sample (dds_sample)
  );

  cplx_mixer u_mix (
    .clk      (clk),
    .i_rst    (i_rst),
    .i_trig   (dds_trig),
    .i_sample (dds_sample),
    .o_mix    (mix)
  );

  scale_round_clip #(
    .SCALE_NUM   (SCALE_NUM),
    .SCALE_SHIFT (SCALE_SHIFT)
  ) u_src (
    .clk   (clk),
    .i_rst (i_rst),
    .i_mix (mix),
    .o_out (o_out)
  );

  assign o_phase = seq_phase; // phase of the sample now leaving the sequencer.

endmodule

//--- tag_rx_pkg.sv
package tag_rx_pkg;

  // sample and tone widths.
  localparam int DATA_W   = 16;
  localparam int PHASE_W  = 24;
  localparam int TRIG_W   = 16;
  localparam int LUT_BITS = 8;

  // mixer results carry the full product sum, one bit above two products.
  localparam int WIDE_W = DATA_W + TRIG_W + 1;

  // one complex sample at the data width.
  typedef struct packed {
    logic                     valid;
    logic                     last;
    logic signed [DATA_W-1:0] i;
    logic signed [DATA_W-1:0] q;
  } iq_t;

  // mixer output before scaling.
  typedef struct packed {
    logic                     valid;
    logic                     last;
    logic signed [WIDE_W-1:0] i;
    logic signed [WIDE_W-1:0] q;
  } wide_iq_t;

  // the local tone, aligned with the sample it belongs to.
  typedef struct packed {
    logic                     valid;
    logic                     last;
    logic signed [TRIG_W-1:0] sin;
    logic signed [TRIG_W-1:0] cos;
  } trig_t;

  // IDLE and SYMB_END both mean the next sample opens a symbol.
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    SYMB_END
  } seq_state_e;

endpackage

//--- tag_rx_props.sv
module tag_rx_props (
  input logic            clk,
  input logic            i_rst,
  input tag_rx_pkg::iq_t i_in,
  input tag_rx_pkg::iq_t o_out,
  input logic            o_sync_ready
);
  import tag_rx_pkg::*;

  // every accepted sample leaves the pipeline four cycles later.
  a_latency: assert property (@(posedge clk) disable iff (i_rst)
    i_in.valid |-> ##4 o_out.valid)
    else $error("output valid missing four cycles after input valid");

  a_rst_quiet: assert property (@(posedge clk) i_rst |=> !o_out.valid)
    else $error("output valid high during reset");

  // the frame counter leaves reset at all ones.
  a_sync_after_rst: assert property (@(posedge clk) $fell(i_rst) |-> o_sync_ready)
    else $error("sync flag low right after reset");

endmodule

bind tag_rx tag_rx_props u_props (
  .clk          (clk),
  .i_rst        (i_rst),
  .i_in         (i_in),
  .o_out        (o_out),
  .o_sync_ready (o_sync_ready)
);

//--- tag_rx_seq.sv
module tag_rx_seq #(
  parameter int                            NSIG         = 8,
  parameter int                            NSYMB        = 4,
  parameter logic [tag_rx_pkg::PHASE_W-1:0] DPH_INC      = '0,
  parameter logic [tag_rx_pkg::PHASE_W-1:0] START_PH     = '0,
  parameter logic [tag_rx_pkg::PHASE_W-1:0] START_PH_INC = '0,
  parameter int                            RX_SYNC_BITS = 2
) (
  input  logic                             clk,
  input  logic                             i_rst,
  input  logic                             i_srst,
  input  tag_rx_pkg::iq_t                  i_in,
  output tag_rx_pkg::iq_t                  o_sample,
  output logic [tag_rx_pkg::PHASE_W-1:0]   o_phase,
  output logic [$clog2(NSYMB+1)-1:0]       o_symb_idx,
  output logic                             o_sync_ready
);
  import tag_rx_pkg::*;

  localparam int SAMP_W = $clog2(NSIG + 1);
  localparam int SYMB_W = $clog2(NSYMB + 1);

  seq_state_e                state, nxt_state;
  logic [SAMP_W-1:0]         samp_idx, nxt_samp;
  logic [SYMB_W-1:0]         symb_idx, nxt_symb;
  logic [PHASE_W-1:0]        ph_inc, nxt_inc;
  logic [PHASE_W-1:0]        phase, nxt_phase;
  logic [RX_SYNC_BITS-1:0]   frame_cnt;
  logic                      frame_end;
  iq_t                       sample_q;

  // the registers describe the sample last sent out, so the next one is derived here.
  always_comb begin
    if (state != RUN) begin
      nxt_samp  = SAMP_W'(1);
      nxt_phase = START_PH;
      if (symb_idx == SYMB_W'(NSYMB)) begin
        nxt_symb = SYMB_W'(1);
        nxt_inc  = START_PH_INC;
      end else begin
        nxt_symb = symb_idx + 1'b1;
        nxt_inc  = ph_inc + DPH_INC; // chirp step between symbols.
      end
    end else begin
      nxt_samp  = samp_idx + 1'b1;
      nxt_symb  = symb_idx;
      nxt_inc   = ph_inc;
      nxt_phase = phase + ph_inc;
    end
    nxt_state = (nxt_samp == SAMP_W'(NSIG)) ? SYMB_END : RUN;
    frame_end = (nxt_samp == SAMP_W'(NSIG)) && (nxt_symb == SYMB_W'(NSYMB));
  end

  always_ff @(posedge clk) begin
    if (i_rst || i_srst) begin
      state     <= IDLE;
      samp_idx  <= SAMP_W'(NSIG); // first sample then opens symbol 1.
      symb_idx  <= SYMB_W'(NSYMB);
      ph_inc    <= START_PH_INC;
      phase     <= START_PH;
      frame_cnt <= '1;
    end else if (i_in.valid) begin
      state    <= nxt_state;
      samp_idx <= nxt_samp;
      symb_idx <= nxt_symb;
      ph_inc   <= nxt_inc;
      phase    <= nxt_phase;
      if (frame_end) begin
        frame_cnt <= frame_cnt + 1'b1;
      end
    end
  end

  // samples pass on every cycle, gaps included, so the latency stays fixed.
  always_ff @(posedge clk) begin
    if (i_rst) begin
      sample_q.valid <= 1'b0;
    end else begin
      sample_q.valid <= i_in.valid;
    end
    sample_q.last <= i_in.last;
    sample_q.i    <= i_in.i;
    sample_q.q    <= i_in.q;
  end

  assign o_sample     = sample_q;
  assign o_phase      = phase;
  assign o_symb_idx   = symb_idx;
  assign o_sync_ready = &frame_cnt; // high one frame in every 2**RX_SYNC_BITS.

endmodule

//--- tag_rx_testdata.txt
# columns: name, in i, in q, in last, expected out i, expected out q (decimal).
# one frame of 8 samples x 4 symbols; tone phase steps 16, 24, 32, 40 table entries.
s1n0 5000 -7000 0 5000 -7000
s1n1 0 0 0 0 0
s1n2 0 0 0 0 0
s1n3 0 0 0 0 0
s1n4 0 0 0 0 0
s1n5 0 0 0 0 0
s1n6 0 0 0 0 0
s1n7 0 0 1 0 0
s2n0 -16000 12000 0 -16000 12000
s2n1 0 0 0 0 0
s2n2 0 0 0 0 0
s2n3 0 0 0 0 0
s2n4 0 0 0 0 0
s2n5 0 0 0 0 0
s2n6 0 0 0 0 0
s2n7 0 0 1 0 0
s3n0 100 -100 0 100 -100
s3n1 1000 0 0 707 -707
s3n2 300 -200 0 -200 -300
s3n3 0 1000 0 707 -707
s3n4 -1234 567 0 1234 -567
s3n5 1000 1000 0 -1414 0
s3n6 2000 -3000 0 3000 2000
s3n7 -1000 500 1 -1061 -354
s4n0 -1 1 0 -1 1
s4n1 0 0 0 0 0
s4n2 0 0 0 0 0
s4n3 0 0 0 0 0
s4n4 0 0 0 0 0
s4n5 0 0 0 0 0
s4n6 0 0 0 0 0
s4n7 0 0 1 0 0

//--- tb.f
tag_rx_pkg.sv
tag_rx_seq.sv
dds_sincos.sv
cplx_mixer.sv
scale_round_clip.sv
tag_rx.sv
tag_rx_props.sv
tb_checker.sv
tb.sv

//--- tb.sv
module tb;
  import tag_rx_pkg::*;

  localparam int                 NSIG         = 8;
  localparam int                 NSYMB        = 4;
  localparam logic [PHASE_W-1:0] DPH_INC      = 24'h080000;
  localparam logic [PHASE_W-1:0] START_PH     = 24'h000000;
  localparam logic [PHASE_W-1:0] START_PH_INC = 24'h100000;
  localparam int                 RX_SYNC_BITS = 2;
  localparam int                 N_EXTRA      = 142; // ends inside the sixth frame, flag low.
  localparam int                 N_AFTER      = 12;

  logic                       clk;
  logic                       i_rst;
  logic                       i_srst;
  iq_t                        i_in;
  iq_t                        o_out;
  logic                       o_sync_ready;
  logic [PHASE_W-1:0]         o_phase;
  logic [$clog2(NSYMB+1)-1:0] o_symb_idx;

  string names[$];
  int    f_i[$];
  int    f_q[$];
  int    f_last[$];
  int    f_ei[$];
  int    f_eq[$];
  int    cycles = 0;
  int    limit = 0;
  int    tb_errors = 0;

  tag_rx #(
    .NSIG(NSIG), .NSYMB(NSYMB), .DPH_INC(DPH_INC), .START_PH(START_PH),
    .START_PH_INC(START_PH_INC), .RX_SYNC_BITS(RX_SYNC_BITS),
    .SCALE_NUM(1), .SCALE_SHIFT(15)
  ) uut (
    .clk(clk), .i_rst(i_rst), .i_srst(i_srst), .i_in(i_in), .o_out(o_out),
    .o_sync_ready(o_sync_ready), .o_phase(o_phase), .o_symb_idx(o_symb_idx)
  );

  tb_checker #(
    .NSIG(NSIG), .NSYMB(NSYMB), .DPH_INC(DPH_INC), .START_PH(START_PH),
    .START_PH_INC(START_PH_INC), .RX_SYNC_BITS(RX_SYNC_BITS)
  ) u_chk (
    .clk(clk), .i_rst(i_rst), .i_srst(i_srst), .i_in(i_in), .o_out(o_out),
    .o_sync_ready(o_sync_ready), .o_phase(o_phase), .o_symb_idx(o_symb_idx)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic load_testdata();
    int    fd;
    int    n;
    int    vi, vq, vl, ei, eq;
    string line;
    string name;
    fd = $fopen("tag_rx_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open tag_rx_testdata.txt");
      tb_errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() > 1 && line[0] != 8'h23) begin // skip comments and blank lines.
        n = $sscanf(line, "%s %d %d %d %d %d", name, vi, vq, vl, ei, eq);
        if (n == 6) begin
          names.push_back(name);
          f_i.push_back(vi);
          f_q.push_back(vq);
          f_last.push_back(vl);
          f_ei.push_back(ei);
          f_eq.push_back(eq);
        end
      end
    end
    $fclose(fd);
  endtask

  // called on a falling edge; the sample is held for one cycle.
  task automatic send(input string name, input int vi, input int vq, input int vl,
                      input int ei, input int eq);
    i_in.valid = 1'b1;
    i_in.last  = (vl != 0);
    i_in.i     = vi[DATA_W-1:0];
    i_in.q     = vq[DATA_W-1:0];
    u_chk.push_expect(name, ei, eq);
    @(negedge clk);
    i_in.valid = 1'b0;
    i_in.last  = 1'b0;
  endtask

  task automatic send_zeros(input int n, input string tag);
    int gap;
    for (int k = 0; k < n; k++) begin
      send($sformatf("%s%0d", tag, k), 0, 0, ((k % 8) == 7) ? 1 : 0, 0, 0);
      gap = $urandom_range(0, 2);
      repeat (gap) @(negedge clk);
    end
  endtask

  initial begin
    void'($urandom(32'hce96_94cc));
    i_rst  = 1'b1;
    i_srst = 1'b0;
    i_in   = '0;
    load_testdata();
    if (names.size() != NSIG * NSYMB) begin
      $display("data file gave %0d samples instead of %0d", names.size(), NSIG * NSYMB);
      tb_errors++;
    end
    limit = 4 * (names.size() + N_EXTRA + N_AFTER) + 100;
    repeat (5) @(negedge clk);
    i_rst = 1'b0;
    @(negedge clk);
    for (int k = 0; k < names.size(); k++) begin
      send(names[k], f_i[k], f_q[k], f_last[k], f_ei[k], f_eq[k]);
    end
    send_zeros(N_EXTRA, "zero");
    // restart in the middle of a frame, between samples.
    @(negedge clk);
    i_srst = 1'b1;
    @(negedge clk);
    i_srst = 1'b0;
    if (o_sync_ready !== 1'b1) begin
      $display("sync flag is not high after the restart");
      tb_errors++;
    end
    send_zeros(N_AFTER, "restart");
    while (u_chk.pending() != 0) begin
      @(negedge clk);
    end
    repeat (8) @(negedge clk);
    $display("errors: value %0d, other %0d, outputs checked %0d", u_chk.value_errors,
             u_chk.other_errors + tb_errors, u_chk.n_out);
    if (u_chk.value_errors + u_chk.other_errors + tb_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- tb_checker.sv
module tb_checker #(
  parameter int                             NSIG         = 8,
  parameter int                             NSYMB        = 4,
  parameter logic [tag_rx_pkg::PHASE_W-1:0] DPH_INC      = '0,
  parameter logic [tag_rx_pkg::PHASE_W-1:0] START_PH     = '0,
  parameter logic [tag_rx_pkg::PHASE_W-1:0] START_PH_INC = '0,
  parameter int                             RX_SYNC_BITS = 2
) (
  input logic                           clk,
  input logic                           i_rst,
  input logic                           i_srst,
  input tag_rx_pkg::iq_t                i_in,
  input tag_rx_pkg::iq_t                o_out,
  input logic                           o_sync_ready,
  input logic [tag_rx_pkg::PHASE_W-1:0] o_phase,
  input logic [$clog2(NSYMB+1)-1:0]     o_symb_idx
);
  import tag_rx_pkg::*;

  string                   exp_name[$];
  int                      exp_i[$];
  int                      exp_q[$];
  int                      in_cycle[$];
  logic                    in_last[$];
  int                      cycle = 0;
  int                      value_errors = 0;
  int                      other_errors = 0;
  int                      n_out = 0;
  int                      n_in = 0;
  int                      m_samp = NSIG;
  int                      m_symb = NSYMB;
  logic [PHASE_W-1:0]      m_inc = START_PH_INC;
  logic [PHASE_W-1:0]      m_ph = START_PH;
  logic [RX_SYNC_BITS-1:0] m_frame = '1;
  logic                    chk_phase = 1'b0;
  logic                    started = 1'b0;
  logic                    in_rst = 1'b1;

  task automatic push_expect(input string name, input int ei, input int eq);
    exp_name.push_back(name);
    exp_i.push_back(ei);
    exp_q.push_back(eq);
  endtask

  function automatic int pending();
    return exp_name.size();
  endfunction

  // reference model of the phase sequencer, advanced by valid samples only.
  always @(posedge clk) begin
    cycle = cycle + 1;
    started = 1'b1;
    in_rst = i_rst;
    chk_phase = 1'b0;
    if (i_rst || i_srst) begin
      m_samp  = NSIG;
      m_symb  = NSYMB;
      m_inc   = START_PH_INC;
      m_ph    = START_PH;
      m_frame = '1;
    end else if (i_in.valid) begin
      if (m_samp == NSIG) begin
        m_samp = 1;
        m_ph   = START_PH;
        if (m_symb == NSYMB) begin
          m_symb = 1;
          m_inc  = START_PH_INC;
        end else begin
          m_symb = m_symb + 1;
          m_inc  = m_inc + DPH_INC;
        end
      end else begin
        m_samp = m_samp + 1;
        m_ph   = m_ph + m_inc;
      end
      if (m_samp == NSIG && m_symb == NSYMB) begin
        m_frame = m_frame + 1'b1;
      end
      chk_phase = 1'b1;
      n_in = n_in + 1;
    end
    if (!i_rst && i_in.valid) begin
      in_cycle.push_back(cycle);
      in_last.push_back(i_in.last);
    end
  end

  // outputs are compared half a cycle after the edge that set them.
  always @(negedge clk) begin
    string name;
    int    ei;
    int    eq;
    int    c;
    int    lat;
    logic  lst;
    if (started && in_rst && o_out.valid) begin
      $display("output valid is high while reset is applied");
      other_errors++;
    end
    if (started && (o_sync_ready !== (&m_frame))) begin
      $display("Fail sync at cycle %0d: expected %0b, actual %0b", cycle, &m_frame, o_sync_ready);
      value_errors++;
    end
    if (chk_phase) begin
      if (o_phase !== m_ph) begin
        $display("Fail phase#%0d: expected %h, actual %h", n_in, m_ph, o_phase);
        value_errors++;
      end
      if (int'(o_symb_idx) != m_symb) begin
        $display("Fail symbol#%0d: expected %0d, actual %0d", n_in, m_symb, o_symb_idx);
        value_errors++;
      end
    end
    if (!in_rst && o_out.valid) begin
      if (exp_name.size() == 0 || in_cycle.size() == 0) begin
        $display("output sample appeared with no input sample waiting for it");
        other_errors++;
      end else begin
        name = exp_name.pop_front();
        ei   = exp_i.pop_front();
        eq   = exp_q.pop_front();
        c    = in_cycle.pop_front();
        lst  = in_last.pop_front();
        lat  = cycle + 1 - c; // the output is sampled at the edge after the one that set it.
        n_out++;
        if (lat != 4) begin
          $display("output for %s came %0d cycles after its input, not 4", name, lat);
          other_errors++;
        end
        if (o_out.last !== lst) begin
          $display("Fail %s last: expected %0b, actual %0b", name, lst, o_out.last);
          value_errors++;
        end
        if (int'($signed(o_out.i)) != ei || int'($signed(o_out.q)) != eq) begin
          $display("Fail %s: expected i=%0d q=%0d, actual i=%0d q=%0d", name, ei, eq,
                   $signed(o_out.i), $signed(o_out.q));
          value_errors++;
        end
      end
    end
  end

endmodule
